// File: src/llc_cfg_pkg.sv
package llc_cfg_pkg;

    localparam int LLC_WAYS   = 2;
    localparam int LLC_SETS   = 8;
    localparam int LINE_WORDS = 4;
    localparam int WORD_BITS  = 32;
    localparam int ADDR_BITS  = 16;

    // Derived field widths of a byte address.
    localparam int BYTE_BITS = $clog2(WORD_BITS / 8);
    localparam int OFF_BITS  = $clog2(LINE_WORDS);
    localparam int SET_BITS  = $clog2(LLC_SETS);
    localparam int WAY_BITS  = $clog2(LLC_WAYS);
    localparam int TAG_BITS  = ADDR_BITS - SET_BITS - OFF_BITS - BYTE_BITS;

endpackage

// File: src/llc_msg_pkg.sv
package llc_msg_pkg;

    import llc_cfg_pkg::*;

    // One byte address, seen raw or split into its cache fields.
    typedef union packed {
        logic [ADDR_BITS-1:0] word_addr;
        struct packed {
            logic [TAG_BITS-1:0]  tag;
            logic [SET_BITS-1:0]  set;
            logic [OFF_BITS-1:0]  word_off;
            logic [BYTE_BITS-1:0] byte_off;
        } fields;
    } llc_addr_u;

    typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;

    typedef enum logic [2:0] {
        RST_SWEEP,
        DECODE,
        READ,
        LOOKUP,
        PROCESS,
        UPDATE,
        RESPOND
    } llc_state_e;

endpackage

// File: src/llc_input_arbiter.sv
`timescale 1ns/1ps

module llc_input_arbiter
    import llc_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_cyc_i,
    input  logic                 cpu_stb_i,
    input  logic                 cpu_we_i,
    input  logic [ADDR_BITS-1:0] cpu_adr_i,
    input  logic [WORD_BITS-1:0] cpu_dat_i,
    output logic [WORD_BITS-1:0] cpu_dat_o,
    output logic                 cpu_ack_o,
    input  logic                 dma_cyc_i,
    input  logic                 dma_stb_i,
    input  logic                 dma_we_i,
    input  logic [ADDR_BITS-1:0] dma_adr_i,
    input  logic [WORD_BITS-1:0] dma_dat_i,
    output logic [WORD_BITS-1:0] dma_dat_o,
    output logic                 dma_ack_o,
    input  logic                 req_done_i,
    input  logic [WORD_BITS-1:0] req_rdata_i,
    output logic                 req_valid_o,
    output logic                 req_dma_o,
    output logic                 req_we_o,
    output logic [ADDR_BITS-1:0] req_adr_o,
    output logic [WORD_BITS-1:0] req_wdata_o
);

    logic cpu_req, dma_req, pick_dma, grant;
    logic busy, last_dma;
    logic [WORD_BITS-1:0] rdata_q;

    assign cpu_req  = cpu_cyc_i & cpu_stb_i;
    assign dma_req  = dma_cyc_i & dma_stb_i;
    assign pick_dma = dma_req & (~cpu_req | ~last_dma); // DMA wins a tie if the CPU went last.
    assign grant    = ~busy & (cpu_req | dma_req);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy        <= 1'b0;
            last_dma    <= 1'b0;
            req_valid_o <= 1'b0;
            req_dma_o   <= 1'b0;
            cpu_ack_o   <= 1'b0;
            dma_ack_o   <= 1'b0;
        end else begin
            cpu_ack_o <= 1'b0;
            dma_ack_o <= 1'b0;
            if (grant) begin
                busy        <= 1'b1;
                req_valid_o <= 1'b1;
                req_dma_o   <= pick_dma;
                last_dma    <= pick_dma;
            end else if (req_valid_o && req_done_i) begin
                req_valid_o <= 1'b0;
                cpu_ack_o   <= ~req_dma_o;
                dma_ack_o   <= req_dma_o;
            end else if (cpu_ack_o || dma_ack_o) begin
                busy <= 1'b0; // The ack cycle lets the master drop stb.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            req_we_o    <= pick_dma ? dma_we_i : cpu_we_i;
            req_adr_o   <= pick_dma ? dma_adr_i : cpu_adr_i;
            req_wdata_o <= pick_dma ? dma_dat_i : cpu_dat_i;
        end
        if (req_done_i) begin
            rdata_q <= req_rdata_i;
        end
    end

    assign cpu_dat_o = rdata_q;
    assign dma_dat_o = rdata_q;

endmodule

// File: src/llc_tag_store.sv
`timescale 1ns/1ps

module llc_tag_store
    import llc_cfg_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rd_en_i,
    input  logic [SET_BITS-1:0]                rd_set_i,
    input  logic                               wr_en_i,
    input  logic [SET_BITS-1:0]                wr_set_i,
    input  logic [LLC_WAYS-1:0]                wr_way_i,  // One bit per way.
    input  logic                               wr_valid_i,
    input  logic                               wr_dirty_i,
    input  logic [TAG_BITS-1:0]                wr_tag_i,
    input  logic                               evict_wr_en_i,
    input  logic [WAY_BITS-1:0]                evict_way_i,
    output logic [LLC_WAYS-1:0]                rd_valid_o,
    output logic [LLC_WAYS-1:0]                rd_dirty_o,
    output logic [LLC_WAYS-1:0][TAG_BITS-1:0]  rd_tag_o,
    output logic [WAY_BITS-1:0]                rd_evict_way_o
);

    logic [LLC_WAYS-1:0]               valid_mem [LLC_SETS];
    logic [LLC_WAYS-1:0]               dirty_mem [LLC_SETS];
    logic [LLC_WAYS-1:0][TAG_BITS-1:0] tag_mem   [LLC_SETS];
    logic [WAY_BITS-1:0]               evict_mem [LLC_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (wr_en_i && wr_way_i[w]) begin
                valid_mem[wr_set_i][w] <= wr_valid_i;
                dirty_mem[wr_set_i][w] <= wr_dirty_i;
                tag_mem[wr_set_i][w]   <= wr_tag_i;
            end
        end
        if (evict_wr_en_i) begin
            evict_mem[wr_set_i] <= evict_way_i;
        end
        if (rd_en_i) begin
            rd_tag_o <= tag_mem[rd_set_i];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid_o     <= '0;
            rd_dirty_o     <= '0;
            rd_evict_way_o <= '0;
        end else if (rd_en_i) begin
            rd_valid_o     <= valid_mem[rd_set_i];
            rd_dirty_o     <= dirty_mem[rd_set_i];
            rd_evict_way_o <= evict_mem[rd_set_i];
        end
    end

endmodule

// File: src/llc_data_store.sv
`timescale 1ns/1ps

module llc_data_store
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;
(
    input  logic                       clk,
    input  logic                       rd_en_i,
    input  logic [SET_BITS-1:0]        rd_set_i,
    input  logic                       wr_en_i,
    input  logic [SET_BITS-1:0]        wr_set_i,
    input  logic [WAY_BITS-1:0]        wr_way_i,
    input  line_t                      wr_line_i,
    output line_t [LLC_WAYS-1:0]       rd_line_o
);

    line_t [LLC_WAYS-1:0] line_mem [LLC_SETS];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            line_mem[wr_set_i][wr_way_i] <= wr_line_i; // Whole line, one way.
        end
        if (rd_en_i) begin
            rd_line_o <= line_mem[rd_set_i];
        end
    end

endmodule

// File: src/llc_controller.sv
`timescale 1ns/1ps

module llc_controller
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req_valid_i,
    input  logic                               req_dma_i,
    input  logic                               req_we_i,
    input  logic [ADDR_BITS-1:0]               req_adr_i,
    input  logic [WORD_BITS-1:0]               req_wdata_i,
    output logic                               req_done_o,
    output logic [WORD_BITS-1:0]               req_rdata_o,
    output logic                               rd_en_o,
    output logic [SET_BITS-1:0]                rd_set_o,
    input  logic [LLC_WAYS-1:0]                rd_valid_i,
    input  logic [LLC_WAYS-1:0]                rd_dirty_i,
    input  logic [LLC_WAYS-1:0][TAG_BITS-1:0]  rd_tag_i,
    input  logic [WAY_BITS-1:0]                rd_evict_way_i,
    input  line_t [LLC_WAYS-1:0]               rd_line_i,
    output logic                               tag_wr_en_o,
    output logic [LLC_WAYS-1:0]                tag_wr_way_o,
    output logic [SET_BITS-1:0]                wr_set_o,
    output logic                               wr_valid_o,
    output logic                               wr_dirty_o,
    output logic [TAG_BITS-1:0]                wr_tag_o,
    output logic                               evict_wr_en_o,
    output logic [WAY_BITS-1:0]                evict_way_o,
    output logic                               data_wr_en_o,
    output logic [WAY_BITS-1:0]                data_wr_way_o,
    output line_t                              wr_line_o,
    output logic                               mem_cyc_o,
    output logic                               mem_stb_o,
    output logic                               mem_we_o,
    output logic [ADDR_BITS-1:0]               mem_adr_o,
    output logic [WORD_BITS-1:0]               mem_dat_o,
    input  logic [WORD_BITS-1:0]               mem_dat_i,
    input  logic                               mem_ack_i
);

    llc_state_e state, next_state;
    llc_addr_u req_addr, mem_addr;
    logic [SET_BITS-1:0] sweep_set;
    logic sweep, hit, store_wr, mem_busy, wb_phase, proc_done, hit_q, sel_dirty_q;
    logic [WAY_BITS-1:0] hit_way, sel_way, way_q, evict_q, next_evict;
    logic [TAG_BITS-1:0] sel_tag_q;
    logic [OFF_BITS-1:0] cnt, mem_idx;
    line_t line_buf, upd_line;

    assign req_addr.word_addr = req_adr_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= RST_SWEEP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RST_SWEEP: if (sweep_set == SET_BITS'(LLC_SETS - 1)) next_state = DECODE;
            DECODE:    if (req_valid_i) next_state = READ;
            READ:      next_state = LOOKUP;
            LOOKUP:    next_state = hit ? UPDATE : PROCESS;
            PROCESS:   if (proc_done) next_state = UPDATE;
            UPDATE:    next_state = RESPOND;
            RESPOND:   next_state = DECODE;
            default:   next_state = DECODE;
        endcase
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (rd_valid_i[w] && rd_tag_i[w] == req_addr.fields.tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign sel_way    = hit ? hit_way : rd_evict_way_i;
    assign next_evict = (evict_q == WAY_BITS'(LLC_WAYS - 1)) ? '0 : evict_q + 1'b1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_set   <= '0;
            hit_q       <= 1'b0;
            way_q       <= '0;
            evict_q     <= '0;
            sel_dirty_q <= 1'b0;
            wb_phase    <= 1'b0;
            proc_done   <= 1'b0;
            cnt         <= '0;
            mem_busy    <= 1'b0;
        end else begin
            if (sweep) begin
                sweep_set <= sweep_set + 1'b1;
            end
            if (state == LOOKUP) begin
                hit_q       <= hit;
                way_q       <= sel_way;
                evict_q     <= rd_evict_way_i;
                sel_dirty_q <= rd_dirty_i[sel_way];
                wb_phase    <= !hit && !req_dma_i && rd_valid_i[sel_way] && rd_dirty_i[sel_way];
                proc_done   <= 1'b0;
                cnt         <= '0;
            end
            if (state == PROCESS) begin
                if (!mem_busy) begin
                    mem_busy <= !proc_done; // Stb stays low for a cycle between words.
                end else if (mem_ack_i) begin
                    mem_busy <= 1'b0;
                    if (req_dma_i) begin
                        proc_done <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                        if (cnt == OFF_BITS'(LINE_WORDS - 1)) begin
                            wb_phase  <= 1'b0;
                            proc_done <= !wb_phase; // The fill follows a writeback.
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            line_buf  <= rd_line_i[sel_way];
            sel_tag_q <= rd_tag_i[sel_way];
        end else if (state == PROCESS && mem_busy && mem_ack_i && !mem_we_o) begin
            line_buf[mem_idx] <= mem_dat_i;
        end
        if (state == UPDATE) begin
            req_rdata_o <= upd_line[req_addr.fields.word_off];
        end
    end

    always_comb begin
        upd_line = line_buf;
        if (req_we_i) begin
            upd_line[req_addr.fields.word_off] = req_wdata_i;
        end
    end

    assign sweep    = (state == RST_SWEEP);
    assign store_wr = (state == UPDATE) && (hit_q || !req_dma_i); // DMA misses never allocate.

    assign rd_en_o       = (state == READ);
    assign rd_set_o      = req_addr.fields.set;
    assign tag_wr_en_o   = sweep || store_wr;
    assign tag_wr_way_o  = sweep ? '1 : (LLC_WAYS'(1) << way_q);
    assign wr_set_o      = sweep ? sweep_set : req_addr.fields.set;
    assign wr_valid_o    = !sweep;
    assign wr_dirty_o    = !sweep && ((hit_q && sel_dirty_q) || req_we_i);
    assign wr_tag_o      = req_addr.fields.tag;
    assign evict_wr_en_o = sweep || (state == UPDATE && !hit_q && !req_dma_i);
    assign evict_way_o   = sweep ? '0 : next_evict;
    assign data_wr_en_o  = store_wr;
    assign data_wr_way_o = way_q;
    assign wr_line_o     = upd_line;
    assign req_done_o    = (state == RESPOND);

    always_comb begin
        mem_addr = req_addr;
        mem_addr.fields.byte_off = '0;
        if (!req_dma_i) begin
            mem_addr.fields.word_off = cnt;
            if (wb_phase) begin
                mem_addr.fields.tag = sel_tag_q; // Victim line address.
            end
        end
    end

    assign mem_idx   = req_dma_i ? req_addr.fields.word_off : cnt;
    assign mem_cyc_o = mem_busy;
    assign mem_stb_o = mem_busy;
    assign mem_we_o  = req_dma_i ? req_we_i : wb_phase;
    assign mem_adr_o = mem_addr.word_addr;
    assign mem_dat_o = req_dma_i ? req_wdata_i : line_buf[cnt];

endmodule

// File: src/llc_top.sv
`timescale 1ns/1ps

module llc_top
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_cyc_i,
    input  logic                 cpu_stb_i,
    input  logic                 cpu_we_i,
    input  logic [ADDR_BITS-1:0] cpu_adr_i,
    input  logic [WORD_BITS-1:0] cpu_dat_i,
    output logic [WORD_BITS-1:0] cpu_dat_o,
    output logic                 cpu_ack_o,
    input  logic                 dma_cyc_i,
    input  logic                 dma_stb_i,
    input  logic                 dma_we_i,
    input  logic [ADDR_BITS-1:0] dma_adr_i,
    input  logic [WORD_BITS-1:0] dma_dat_i,
    output logic [WORD_BITS-1:0] dma_dat_o,
    output logic                 dma_ack_o,
    output logic                 mem_cyc_o,
    output logic                 mem_stb_o,
    output logic                 mem_we_o,
    output logic [ADDR_BITS-1:0] mem_adr_o,
    output logic [WORD_BITS-1:0] mem_dat_o,
    input  logic [WORD_BITS-1:0] mem_dat_i,
    input  logic                 mem_ack_i
);

    logic req_valid, req_dma, req_we, req_done;
    logic [ADDR_BITS-1:0] req_adr;
    logic [WORD_BITS-1:0] req_wdata, req_rdata;
    logic rd_en, tag_wr_en, wr_valid, wr_dirty, evict_wr_en, data_wr_en;
    logic [SET_BITS-1:0] rd_set, wr_set;
    logic [LLC_WAYS-1:0] tag_wr_way, rd_valid, rd_dirty;
    logic [TAG_BITS-1:0] wr_tag;
    logic [LLC_WAYS-1:0][TAG_BITS-1:0] rd_tag;
    logic [WAY_BITS-1:0] evict_way, rd_evict_way, data_wr_way;
    line_t wr_line;
    line_t [LLC_WAYS-1:0] rd_line;

    llc_input_arbiter arbiter_u (
        .clk, .rst,
        .cpu_cyc_i, .cpu_stb_i, .cpu_we_i, .cpu_adr_i, .cpu_dat_i, .cpu_dat_o, .cpu_ack_o,
        .dma_cyc_i, .dma_stb_i, .dma_we_i, .dma_adr_i, .dma_dat_i, .dma_dat_o, .dma_ack_o,
        .req_done_i(req_done), .req_rdata_i(req_rdata),
        .req_valid_o(req_valid), .req_dma_o(req_dma), .req_we_o(req_we),
        .req_adr_o(req_adr), .req_wdata_o(req_wdata)
    );

    llc_controller controller_u (
        .clk, .rst,
        .req_valid_i(req_valid), .req_dma_i(req_dma), .req_we_i(req_we),
        .req_adr_i(req_adr), .req_wdata_i(req_wdata),
        .req_done_o(req_done), .req_rdata_o(req_rdata),
        .rd_en_o(rd_en), .rd_set_o(rd_set),
        .rd_valid_i(rd_valid), .rd_dirty_i(rd_dirty), .rd_tag_i(rd_tag),
        .rd_evict_way_i(rd_evict_way), .rd_line_i(rd_line),
        .tag_wr_en_o(tag_wr_en), .tag_wr_way_o(tag_wr_way), .wr_set_o(wr_set),
        .wr_valid_o(wr_valid), .wr_dirty_o(wr_dirty), .wr_tag_o(wr_tag),
        .evict_wr_en_o(evict_wr_en), .evict_way_o(evict_way),
        .data_wr_en_o(data_wr_en), .data_wr_way_o(data_wr_way), .wr_line_o(wr_line),
        .mem_cyc_o, .mem_stb_o, .mem_we_o, .mem_adr_o, .mem_dat_o, .mem_dat_i, .mem_ack_i
    );

    llc_tag_store tag_store_u (
        .clk, .rst,
        .rd_en_i(rd_en), .rd_set_i(rd_set),
        .wr_en_i(tag_wr_en), .wr_set_i(wr_set), .wr_way_i(tag_wr_way),
        .wr_valid_i(wr_valid), .wr_dirty_i(wr_dirty), .wr_tag_i(wr_tag),
        .evict_wr_en_i(evict_wr_en), .evict_way_i(evict_way),
        .rd_valid_o(rd_valid), .rd_dirty_o(rd_dirty), .rd_tag_o(rd_tag),
        .rd_evict_way_o(rd_evict_way)
    );

    llc_data_store data_store_u (
        .clk,
        .rd_en_i(rd_en), .rd_set_i(rd_set),
        .wr_en_i(data_wr_en), .wr_set_i(wr_set), .wr_way_i(data_wr_way),
        .wr_line_i(wr_line),
        .rd_line_o(rd_line)
    );

endmodule

// File: tests/llc_mem_model.sv
`timescale 1ns/1ps

module llc_mem_model
    import llc_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [ADDR_BITS-1:0] adr_i,
    input  logic [WORD_BITS-1:0] dat_i,
    output logic [WORD_BITS-1:0] dat_o,
    output logic                 ack_o,
    output int                   rd_count_o,
    output int                   wr_count_o
);

    localparam int MEM_WORDS = 1 << (ADDR_BITS - BYTE_BITS);

    logic [WORD_BITS-1:0] mem [MEM_WORDS];
    logic                 pending;
    logic [1:0]           delay;

    function automatic logic [WORD_BITS-1:0] preload_word(input int idx);
        return 32'hC0DE_0000 | WORD_BITS'(idx); // Every word carries its own address.
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = preload_word(i);
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack_o      <= 1'b0;
            dat_o      <= '0;
            pending    <= 1'b0;
            delay      <= 2'd0;
            rd_count_o <= 0;
            wr_count_o <= 0;
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !ack_o) begin
                if (!pending) begin
                    pending <= 1'b1;
                    delay   <= 2'($urandom_range(2, 0)); // Ack comes 1 to 3 cycles later.
                end else if (delay != 2'd0) begin
                    delay <= delay - 2'd1;
                end else begin
                    pending <= 1'b0;
                    ack_o   <= 1'b1;
                    if (we_i) begin
                        mem[adr_i[ADDR_BITS-1:BYTE_BITS]] <= dat_i;
                        wr_count_o <= wr_count_o + 1;
                    end else begin
                        dat_o      <= mem[adr_i[ADDR_BITS-1:BYTE_BITS]];
                        rd_count_o <= rd_count_o + 1;
                    end
                end
            end
        end
    end

endmodule

// File: tests/llc_tb.sv
`timescale 1ns/1ps

module llc_tb
    import llc_cfg_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 5;
    localparam int MEM_WORDS  = 1 << (ADDR_BITS - BYTE_BITS);
    localparam int XFERS      = 1 + 5 + 5 + 4 + 80; // Transfers over all tests.
    localparam int XFER_WORST = 60;

    logic clk, rst;
    logic cpu_cyc_i, cpu_stb_i, cpu_we_i, cpu_ack_o;
    logic dma_cyc_i, dma_stb_i, dma_we_i, dma_ack_o;
    logic [ADDR_BITS-1:0] cpu_adr_i, dma_adr_i, mem_adr_o;
    logic [WORD_BITS-1:0] cpu_dat_i, cpu_dat_o, dma_dat_i, dma_dat_o, mem_dat_o, mem_dat_i;
    logic mem_cyc_o, mem_stb_o, mem_we_o, mem_ack_i;
    int rd_count, wr_count, rd_base, wr_base;
    int checks, mismatches, other_errors;
    logic [WORD_BITS-1:0] golden [MEM_WORDS];

    llc_top llc_top_i (.*);

    llc_mem_model mem_u (
        .clk, .rst,
        .cyc_i(mem_cyc_o), .stb_i(mem_stb_o), .we_i(mem_we_o), .adr_i(mem_adr_o),
        .dat_i(mem_dat_o), .dat_o(mem_dat_i), .ack_o(mem_ack_i),
        .rd_count_o(rd_count), .wr_count_o(wr_count)
    );

    function automatic logic [WORD_BITS-1:0] preload_word(input int idx);
        return 32'hC0DE_0000 | WORD_BITS'(idx);
    endfunction

    function automatic logic [ADDR_BITS-1:0] make_addr(input int tag, input int set_idx,
                                                       input int off);
        return {TAG_BITS'(tag), SET_BITS'(set_idx), OFF_BITS'(off), BYTE_BITS'(0)};
    endfunction

    function automatic int word_index(input logic [ADDR_BITS-1:0] adr);
        return int'(adr[ADDR_BITS-1:BYTE_BITS]);
    endfunction

    task automatic check_value(input string name, input logic [WORD_BITS-1:0] expected,
                               input logic [WORD_BITS-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            mismatches++;
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic mark_counts();
        rd_base = rd_count;
        wr_base = wr_count;
    endtask

    task automatic check_traffic(input string name, input int reads, input int writes);
        check_value({name, " memory reads"}, WORD_BITS'(reads), WORD_BITS'(rd_count - rd_base));
        check_value({name, " memory writes"}, WORD_BITS'(writes), WORD_BITS'(wr_count - wr_base));
    endtask

    task automatic cpu_access(input string name, input logic we,
                              input logic [ADDR_BITS-1:0] adr, input logic [WORD_BITS-1:0] wdata);
        @(negedge clk);
        cpu_cyc_i = 1'b1;
        cpu_stb_i = 1'b1;
        cpu_we_i  = we;
        cpu_adr_i = adr;
        cpu_dat_i = wdata;
        @(negedge clk);
        while (!cpu_ack_o) @(negedge clk);
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        if (we) golden[word_index(adr)] = wdata;
        else check_value(name, golden[word_index(adr)], cpu_dat_o);
    endtask

    task automatic dma_access(input string name, input logic we,
                              input logic [ADDR_BITS-1:0] adr, input logic [WORD_BITS-1:0] wdata);
        @(negedge clk);
        dma_cyc_i = 1'b1;
        dma_stb_i = 1'b1;
        dma_we_i  = we;
        dma_adr_i = adr;
        dma_dat_i = wdata;
        @(negedge clk);
        while (!dma_ack_o) @(negedge clk);
        dma_cyc_i = 1'b0;
        dma_stb_i = 1'b0;
        if (we) golden[word_index(adr)] = wdata;
        else check_value(name, golden[word_index(adr)], dma_dat_o);
    endtask

    task automatic reset_and_fill();
        mark_counts();
        cpu_access("reset and miss fill", 1'b0, make_addr(1, 0, 1), '0);
        check_traffic("reset and miss fill", LINE_WORDS, 0);
    endtask

    task automatic hit_no_traffic();
        mark_counts();
        cpu_access("hit read", 1'b0, make_addr(1, 0, 0), '0);
        cpu_access("hit read", 1'b0, make_addr(1, 0, 2), '0);
        cpu_access("hit read", 1'b0, make_addr(1, 0, 3), '0);
        cpu_access("hit write", 1'b1, make_addr(1, 0, 2), 32'h1234_5678);
        cpu_access("hit read back", 1'b0, make_addr(1, 0, 2), '0);
        check_traffic("hit", 0, 0);
    endtask

    task automatic evict_writeback();
        mark_counts();
        cpu_access("evict first tag", 1'b1, make_addr(3, 2, 0), 32'hAAAA_0300);
        cpu_access("evict second tag", 1'b1, make_addr(4, 2, 1), 32'hBBBB_0401);
        check_traffic("evict fills", 2 * LINE_WORDS, 0);
        mark_counts();
        cpu_access("evict third tag", 1'b0, make_addr(5, 2, 2), '0);
        check_traffic("evict victim", LINE_WORDS, LINE_WORDS);
        check_value("evict written back", 32'hAAAA_0300, mem_u.mem[word_index(make_addr(3, 2, 0))]);
        mark_counts();
        cpu_access("evict survivor", 1'b0, make_addr(4, 2, 1), '0);
        check_traffic("evict survivor", 0, 0); // The second-filled way must still hold its line.
        cpu_access("evict reread", 1'b0, make_addr(3, 2, 0), '0);
    endtask

    task automatic dma_bypass();
        cpu_access("dma dirty setup", 1'b1, make_addr(3, 2, 1), 32'hCCCC_0301);
        mark_counts();
        dma_access("dma dirty read", 1'b0, make_addr(3, 2, 1), '0);
        check_traffic("dma dirty read", 0, 0);
        dma_access("dma bypass write", 1'b1, make_addr(7, 5, 3), 32'hDDDD_0753);
        check_traffic("dma bypass write", 0, 1);
        cpu_access("cpu read after dma write", 1'b0, make_addr(7, 5, 3), '0);
    endtask

    task automatic random_traffic(input logic dma, input int count);
        logic [ADDR_BITS-1:0] adr;
        logic we;
        logic [WORD_BITS-1:0] wdata;
        for (int i = 0; i < count; i++) begin
            adr   = make_addr(8 + $urandom_range(5, 0), $urandom_range(7, 0), $urandom_range(3, 0));
            we    = 1'($urandom_range(1, 0));
            wdata = $urandom;
            if (dma) dma_access("concurrent dma", we, adr, wdata);
            else cpu_access("concurrent cpu", we, adr, wdata);
        end
    endtask

    task automatic print_summary();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (RST_CYCLES + LLC_SETS + XFERS * XFER_WORST) @(posedge clk);
        other_errors++;
        $display("Watchdog expired: a requester never received its ack.");
        print_summary();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(20));
        rst       = 1'b0;
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        cpu_we_i  = 1'b0;
        cpu_adr_i = '0;
        cpu_dat_i = '0;
        dma_cyc_i = 1'b0;
        dma_stb_i = 1'b0;
        dma_we_i  = 1'b0;
        dma_adr_i = '0;
        dma_dat_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            golden[i] = preload_word(i);
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b1;
        reset_and_fill();
        hit_no_traffic();
        evict_writeback();
        dma_bypass();
        fork
            random_traffic(1'b0, 40);
            random_traffic(1'b1, 40);
        join
        print_summary();
        if (mismatches + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/llc_cfg_pkg.sv
src/llc_msg_pkg.sv
src/llc_input_arbiter.sv
src/llc_tag_store.sv
src/llc_data_store.sv
src/llc_controller.sv
src/llc_top.sv
tests/llc_mem_model.sv
tests/llc_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module llc_tb -f verilog.f -o llc_sim
./obj_dir/llc_sim > sim.log
cat sim.log
grep -q "=== PASS ===" sim.log
